// File: sources.f
+incdir+test
src/conv_geom_pkg.sv
src/conv_pos_pkg.sv
src/conv_ingress_pipe.sv
src/conv_pos_tracker.sv
src/conv_line_store.sv
src/conv_col_assembler.sv
src/conv_top.sv
test/tb_conv_top.sv

// File: src/conv_col_assembler.sv
`timescale 1ns/10ps

module conv_col_assembler #(
  parameter int PIXEL_W = 8
) (
    input  wire logic                                          clk
  , input  wire logic                                          reset_i
  , input  wire logic                                          advance_i
  , input  wire logic                                          pos_vld_i
  , input  wire logic [PIXEL_W-1:0]                            pix_s2_i
  , input  wire conv_pos_pkg::kernel_pos_t                     pos_i
  , input  wire logic                                          centre_vld_i
  , input  wire logic [conv_geom_pkg::LB_BANKS-1:0][PIXEL_W-1:0] rd_data_i
  , input  wire conv_geom_pkg::bank_sel_t                      bank_sel_i
  , output logic                                               col_vld_o
  , output conv_pos_pkg::kernel_pos_t                          col_pos_o
  , output logic [conv_geom_pkg::KERNEL_ROWS-1:0][PIXEL_W-1:0] col_data_o
);

  logic                       vld_s3_q;
  logic                       centre_s3_q;
  logic [PIXEL_W-1:0]         pix_s3_q;
  conv_pos_pkg::kernel_pos_t  pos_s3_q;
  logic [conv_geom_pkg::KERNEL_ROWS-1:0][PIXEL_W-1:0] col_data;

  // Stage 3 control, lands together with the bank read words
  always_ff @(posedge clk) begin
    if (reset_i) begin
      vld_s3_q    <= 1'b0;
      centre_s3_q <= 1'b0;
    end else if (advance_i) begin
      vld_s3_q    <= pos_vld_i;
      centre_s3_q <= centre_vld_i;
    end
  end

  // Stage 3 payload
  always_ff @(posedge clk) begin
    if (advance_i) begin
      pix_s3_q <= pix_s2_i;
      pos_s3_q <= pos_i;
    end
  end

  // Put the bank words in age order
  // Bank j took the newest line, so bank j-i holds the line i rows up
  // and bank j itself returned the line four rows up before the write
  always_comb begin
    col_data    = '0;
    col_data[0] = pix_s3_q;
    for (int j = 0; j < conv_geom_pkg::LB_BANKS; j++) begin
      if (bank_sel_i[j]) begin
        for (int i = 1; i < conv_geom_pkg::KERNEL_ROWS; i++) begin
          col_data[i] = rd_data_i[(j - i + conv_geom_pkg::LB_BANKS) % conv_geom_pkg::LB_BANKS];
        end
      end
    end
  end

  // A column leaves only while the pipe moves
  // and only once the centre row has been seen
  assign col_vld_o  = vld_s3_q & centre_s3_q & advance_i;
  assign col_pos_o  = pos_s3_q;
  assign col_data_o = col_data;

  // Registered bank select must line up with a valid stage-3 pixel
  a_sel_onehot: assert property (@(posedge clk) disable iff (reset_i)
    vld_s3_q |-> $onehot(bank_sel_i))
    else $error("stage-3 bank select not one-hot: %b", bank_sel_i);

endmodule : conv_col_assembler

// File: src/conv_geom_pkg.sv
package conv_geom_pkg;

  // Rows in one kernel column, newest line at the bottom
  localparam int KERNEL_ROWS = 5;

  // The newest row comes straight from the stream, so one bank less
  localparam int LB_BANKS = KERNEL_ROWS - 1;

  // Largest line the buffers can hold
  localparam int MAX_LINE_W = 64;

  // Enough bits to index MAX_LINE_W columns
  localparam int LINE_ADDR_W = 6;

  // Column index inside a line
  typedef logic [LINE_ADDR_W-1:0] line_addr_t;

  // One-hot bank pointer, one bit per line bank
  typedef logic [LB_BANKS-1:0] bank_sel_t;

  // Lines seen since frame start
  // Saturates at LB_BANKS, beyond which every row is simply "deep enough"
  typedef logic [2:0] line_cnt_t;

endpackage : conv_geom_pkg

// File: src/conv_ingress_pipe.sv
`timescale 1ns/10ps

module conv_ingress_pipe #(
  parameter int PIXEL_W = 8
) (
    input  wire logic                              clk
  , input  wire logic                              reset_i
  , input  wire logic                              s_tvalid_i
  , input  wire logic [PIXEL_W-1:0]                s_tdata_i
  , input  wire logic                              s_tuser_i
  , input  wire logic                              s_tlast_i
  , input  wire logic                              m_tready_i
  , output logic                                   s_tready_o
  , output logic                                   advance_o
  , output conv_pos_pkg::stream_pos_t [4:1]        pos_hist_o
  , output logic [4:1]                             pos_vld_o
  , output logic [PIXEL_W-1:0]                     pix_s2_o
);

  logic                             advance;
  conv_pos_pkg::stream_pos_t        pos_s0;
  conv_pos_pkg::stream_pos_t [4:1]  pos_hist_q;
  logic [4:1]                       pos_vld_q;
  logic [PIXEL_W-1:0]               pix_s1_q;
  logic [PIXEL_W-1:0]               pix_s2_q;

  // The pipe has no slack, so it moves only when a beat goes in
  // and the consumer can take one out in the same cycle
  assign advance    = s_tvalid_i & m_tready_i;
  // Back-pressure passes straight through
  assign s_tready_o = m_tready_i;

  assign pos_s0 = '{sof: s_tuser_i, eol: s_tlast_i};

  // Flag history, four beats deep
  // Stage 2 is the pixel under determination, 1 is newer, 3 and 4 older
  always_ff @(posedge clk) begin
    if (reset_i) begin
      pos_vld_q  <= '0;
      pos_hist_q <= '0;
    end else if (advance) begin
      pos_vld_q  <= {pos_vld_q[3:1], 1'b1};
      pos_hist_q <= {pos_hist_q[3:1], pos_s0};
    end
  end

  // Pixel only needs to reach stage 2
  always_ff @(posedge clk) begin
    if (advance) begin
      pix_s1_q <= s_tdata_i;
      pix_s2_q <= pix_s1_q;
    end
  end

  assign advance_o  = advance;
  assign pos_hist_o = pos_hist_q;
  assign pos_vld_o  = pos_vld_q;
  assign pix_s2_o   = pix_s2_q;

  // Valids fill from stage 1 downwards and never leave a hole
  a_vld_order: assert property (@(posedge clk) disable iff (reset_i)
    pos_vld_q inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
    else $error("ingress stage valids out of order: %b", pos_vld_q);

endmodule : conv_ingress_pipe

// File: src/conv_line_store.sv
`timescale 1ns/10ps

module conv_line_store #(
  parameter int PIXEL_W = 8
) (
    input  wire logic                                          clk
  , input  wire logic                                          reset_i
  , input  wire logic                                          advance_i
  , input  wire conv_pos_pkg::stream_pos_t [3:2]               pos_hist_i
  , input  wire logic [3:2]                                    pos_vld_i
  , input  wire logic [PIXEL_W-1:0]                            pix_s2_i
  , output logic [conv_geom_pkg::LB_BANKS-1:0][PIXEL_W-1:0]    rd_data_o
  , output conv_geom_pkg::bank_sel_t                           bank_sel_o
);

  logic                       sol_s2;
  logic                       lb_en;
  conv_geom_pkg::line_addr_t  col_q;
  conv_geom_pkg::line_addr_t  col_cur;
  conv_geom_pkg::bank_sel_t   bank_q;
  conv_geom_pkg::bank_sel_t   bank_rot;
  conv_geom_pkg::bank_sel_t   bank_cur;
  logic [conv_geom_pkg::LB_BANKS-1:0][PIXEL_W-1:0] rd_q;

  // Stage-2 pixel starting a line
  assign sol_s2 = pos_vld_i[2]
                & conv_pos_pkg::line_start(pos_hist_i[2], pos_vld_i[3], pos_hist_i[3]);

  // Buffers touched once per pixel leaving stage 2
  assign lb_en = advance_i & pos_vld_i[2];

  // Column of the stage-2 pixel
  // Restarts on the line's first pixel without waiting for the register
  assign col_cur = sol_s2 ? '0 : col_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      col_q <= '0;
    end else if (lb_en) begin
      col_q <= col_cur + 1'b1;
    end
  end

  // Oldest line's bank is the next one to overwrite
  assign bank_rot = {bank_q[conv_geom_pkg::LB_BANKS-2:0],
                     bank_q[conv_geom_pkg::LB_BANKS-1]};

  // Frame start pins allocation to bank 0
  always_comb begin
    bank_cur = bank_q;
    if (sol_s2) begin
      bank_cur = pos_hist_i[2].sof ? conv_geom_pkg::bank_sel_t'(1) : bank_rot;
    end
  end

  // Also serves as the stage-3 copy of the write bank
  always_ff @(posedge clk) begin
    if (reset_i) begin
      bank_q <= '0;
    end else if (lb_en) begin
      bank_q <= bank_cur;
    end
  end

  // One memory per bank
  // All read the same column, only the selected one is written
  for (genvar b = 0; b < conv_geom_pkg::LB_BANKS; b++) begin : g_bank
    logic [PIXEL_W-1:0] mem_q [conv_geom_pkg::MAX_LINE_W];

    always_ff @(posedge clk) begin
      if (lb_en) begin
        // Written bank hands back the word four lines up
        rd_q[b] <= mem_q[col_cur];
        if (bank_cur[b]) begin
          mem_q[col_cur] <= pix_s2_i;
        end
      end
    end
  end

  assign rd_data_o  = rd_q;
  assign bank_sel_o = bank_q;

  // Exactly one bank owns the line being written
  a_bank_onehot: assert property (@(posedge clk) disable iff (reset_i)
    pos_vld_i[2] |-> $onehot(bank_cur))
    else $error("line store bank select not one-hot: %b", bank_cur);

  // A line longer than MAX_LINE_W would wrap the column back to zero mid-line
  a_col_range: assert property (@(posedge clk) disable iff (reset_i)
    (lb_en && !sol_s2) |-> (col_q != '0))
    else $error("line exceeds %0d pixels", conv_geom_pkg::MAX_LINE_W);

endmodule : conv_line_store

// File: src/conv_pos_pkg.sv
package conv_pos_pkg;

  // Side flags that ride along with each stream beat
  typedef struct packed {
    logic sof;
    logic eol;
  } stream_pos_t;

  // Edge flags for the kernel centre pixel
  // West/east describe the column, north the row
  typedef struct packed {
    logic w2;
    logic w1;
    logic e1;
    logic e2;
    logic n2;
    logic n1;
  } kernel_pos_t;

  // A pixel starts a line when it carries sof or its predecessor closed a line
  function automatic logic line_start(
    input stream_pos_t cur,
    input logic        prev_vld,
    input stream_pos_t prev
  );
    return cur.sof | (prev_vld & prev.eol);
  endfunction

endpackage : conv_pos_pkg

// File: src/conv_pos_tracker.sv
`timescale 1ns/10ps

module conv_pos_tracker (
    input  wire logic                              clk
  , input  wire logic                              reset_i
  , input  wire logic                              advance_i
  , input  wire conv_pos_pkg::stream_pos_t [4:1]   pos_hist_i
  , input  wire logic [4:1]                        pos_vld_i
  , output conv_pos_pkg::kernel_pos_t              pos_o
  , output logic                                   centre_vld_o
);

  logic                    pos_w2;
  logic                    pos_w1;
  logic                    pos_e1;
  logic                    pos_e2;
  logic                    sol_s2;
  conv_geom_pkg::line_cnt_t line_cnt_q;
  conv_geom_pkg::line_cnt_t line_cnt_inc;
  conv_geom_pkg::line_cnt_t line_cnt_cur;

  // Column edges for the stage-2 pixel
  //   W2 when it opens a line
  //   W1 when the pixel before it opened a line
  //   E1 when the pixel after it closes the line
  //   E2 when it closes the line itself
  assign pos_w2 = conv_pos_pkg::line_start(pos_hist_i[2], pos_vld_i[3], pos_hist_i[3]);
  assign pos_w1 = pos_vld_i[3]
                & conv_pos_pkg::line_start(pos_hist_i[3], pos_vld_i[4], pos_hist_i[4]);
  assign pos_e1 = pos_vld_i[1] & pos_hist_i[1].eol;
  assign pos_e2 = pos_hist_i[2].eol;

  // A real line start needs a pixel in stage 2
  assign sol_s2 = pos_vld_i[2] & pos_w2;

  // Count of the next line, held at LB_BANKS once the buffers are full
  assign line_cnt_inc = (line_cnt_q == conv_geom_pkg::line_cnt_t'(conv_geom_pkg::LB_BANKS))
                      ? line_cnt_q
                      : line_cnt_q + 1'b1;

  // Row index of the stage-2 pixel
  // The register still holds the previous line while the first pixel sits here
  always_comb begin
    line_cnt_cur = line_cnt_q;
    if (sol_s2) begin
      line_cnt_cur = pos_hist_i[2].sof ? '0 : line_cnt_inc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      line_cnt_q <= '0;
    end else if (advance_i && sol_s2) begin
      line_cnt_q <= line_cnt_cur;
    end
  end

  // Newest line r puts the centre on r-2
  // n2 for centre on the top line, n1 for the one below it
  assign pos_o = '{
    w2: pos_w2,
    w1: pos_w1,
    e1: pos_e1,
    e2: pos_e2,
    n2: (line_cnt_cur == conv_geom_pkg::line_cnt_t'(2)),
    n1: (line_cnt_cur == conv_geom_pkg::line_cnt_t'(3))
  };

  // Centre row exists from the third line on
  assign centre_vld_o = (line_cnt_cur >= conv_geom_pkg::line_cnt_t'(2));

endmodule : conv_pos_tracker

// File: src/conv_top.sv
`timescale 1ns/10ps

module conv_top #(
  parameter int PIXEL_W = 8
) (
    input  wire logic                                          clk
  , input  wire logic                                          reset_i
  , input  wire logic                                          s_tvalid_i
  , input  wire logic [PIXEL_W-1:0]                            s_tdata_i
  , input  wire logic                                          s_tuser_i
  , input  wire logic                                          s_tlast_i
  , input  wire logic                                          m_tready_i
  , output logic                                               s_tready_o
  , output logic                                               col_vld_o
  , output conv_pos_pkg::kernel_pos_t                          col_pos_o
  , output logic [conv_geom_pkg::KERNEL_ROWS-1:0][PIXEL_W-1:0] col_data_o
);

  logic                                             advance;
  conv_pos_pkg::stream_pos_t [4:1]                  pos_hist;
  logic [4:1]                                       pos_vld;
  logic [PIXEL_W-1:0]                               pix_s2;
  conv_pos_pkg::kernel_pos_t                        kernel_pos;
  logic                                             centre_vld;
  logic [conv_geom_pkg::LB_BANKS-1:0][PIXEL_W-1:0]  lb_rd_data;
  conv_geom_pkg::bank_sel_t                         lb_bank_sel;

  // Handshake, advance strobe and flag/pixel delay lines
  conv_ingress_pipe #(.PIXEL_W(PIXEL_W)) u_ingress (
      .clk          (clk)
    , .reset_i      (reset_i)
    , .s_tvalid_i   (s_tvalid_i)
    , .s_tdata_i    (s_tdata_i)
    , .s_tuser_i    (s_tuser_i)
    , .s_tlast_i    (s_tlast_i)
    , .m_tready_i   (m_tready_i)
    , .s_tready_o   (s_tready_o)
    , .advance_o    (advance)
    , .pos_hist_o   (pos_hist)
    , .pos_vld_o    (pos_vld)
    , .pix_s2_o     (pix_s2)
  );

  // Edge flags and row count for the stage-2 pixel
  conv_pos_tracker u_tracker (
      .clk          (clk)
    , .reset_i      (reset_i)
    , .advance_i    (advance)
    , .pos_hist_i   (pos_hist)
    , .pos_vld_i    (pos_vld)
    , .pos_o        (kernel_pos)
    , .centre_vld_o (centre_vld)
  );

  // Line buffers only look at the determination stage and the one behind
  conv_line_store #(.PIXEL_W(PIXEL_W)) u_line_store (
      .clk          (clk)
    , .reset_i      (reset_i)
    , .advance_i    (advance)
    , .pos_hist_i   (pos_hist[3:2])
    , .pos_vld_i    (pos_vld[3:2])
    , .pix_s2_i     (pix_s2)
    , .rd_data_o    (lb_rd_data)
    , .bank_sel_o   (lb_bank_sel)
  );

  // Output register, row ordering and beat validity
  conv_col_assembler #(.PIXEL_W(PIXEL_W)) u_assembler (
      .clk          (clk)
    , .reset_i      (reset_i)
    , .advance_i    (advance)
    , .pos_vld_i    (pos_vld[2])
    , .pix_s2_i     (pix_s2)
    , .pos_i        (kernel_pos)
    , .centre_vld_i (centre_vld)
    , .rd_data_i    (lb_rd_data)
    , .bank_sel_i   (lb_bank_sel)
    , .col_vld_o    (col_vld_o)
    , .col_pos_o    (col_pos_o)
    , .col_data_o   (col_data_o)
  );

endmodule : conv_top

// File: test/tb_conv_cases.svh
`ifndef TB_CONV_CASES_SVH
`define TB_CONV_CASES_SVH

// Columns: line width, frame height, valid duty %, ready duty %, pixel base value
typedef struct packed {
  int         width;
  int         height;
  int         valid_pct;
  int         ready_pct;
  logic [7:0] base;
} frame_case_t;

// Tallest frame in the table, sizes the reference frame store
localparam int MAX_FRAME_H = 8;

localparam int NUM_CASES = 9;

// Rows run back to back, each one a full frame
localparam frame_case_t FRAME_CASES [NUM_CASES] = '{
  // Continuous flow, plain rotation and read-before-write
  '{width: 8,  height: 6, valid_pct: 100, ready_pct: 100, base: 8'h10},
  // Narrowest line, W1 and E1 on the same pixel
  '{width: 3,  height: 5, valid_pct: 100, ready_pct: 100, base: 8'h21},
  // Full buffer depth
  '{width: 64, height: 7, valid_pct: 100, ready_pct: 100, base: 8'h35},
  '{width: 5,  height: 6, valid_pct: 80,  ready_pct: 90,  base: 8'h4a},
  '{width: 12, height: 8, valid_pct: 70,  ready_pct: 75,  base: 8'h5c},
  '{width: 3,  height: 6, valid_pct: 60,  ready_pct: 85,  base: 8'h77},
  // Only one output line
  '{width: 17, height: 3, valid_pct: 90,  ready_pct: 60,  base: 8'h83},
  // No centre row at all
  '{width: 9,  height: 2, valid_pct: 100, ready_pct: 100, base: 8'h90},
  '{width: 6,  height: 8, valid_pct: 75,  ready_pct: 70,  base: 8'ha2}
};

`endif

// File: test/tb_conv_top.sv
`timescale 1ns/10ps

module tb_conv_top;

  localparam int PIXEL_W = 8;

  `include "tb_conv_cases.svh"

  // One expected output column
  // row_mask marks rows that exist in the frame
  typedef struct packed {
    conv_pos_pkg::kernel_pos_t                      pos;
    logic [conv_geom_pkg::KERNEL_ROWS-1:0]          row_mask;
    logic [conv_geom_pkg::KERNEL_ROWS-1:0][PIXEL_W-1:0] data;
  } col_beat_t;

  logic                clk;
  logic                reset_i;
  logic                s_tvalid_i;
  logic [PIXEL_W-1:0]  s_tdata_i;
  logic                s_tuser_i;
  logic                s_tlast_i;
  logic                m_tready_i;
  logic                s_tready_o;
  logic                col_vld_o;
  conv_pos_pkg::kernel_pos_t col_pos_o;
  logic [conv_geom_pkg::KERNEL_ROWS-1:0][PIXEL_W-1:0] col_data_o;

  logic [PIXEL_W-1:0]  frame_pix [MAX_FRAME_H][conv_geom_pkg::MAX_LINE_W];
  col_beat_t           expect_q [$];
  int                  cycle_cnt = 0;
  int                  cycle_limit = 0;

  conv_top #(.PIXEL_W(PIXEL_W)) dut_i (
      .clk        (clk)
    , .reset_i    (reset_i)
    , .s_tvalid_i (s_tvalid_i)
    , .s_tdata_i  (s_tdata_i)
    , .s_tuser_i  (s_tuser_i)
    , .s_tlast_i  (s_tlast_i)
    , .m_tready_i (m_tready_i)
    , .s_tready_o (s_tready_o)
    , .col_vld_o  (col_vld_o)
    , .col_pos_o  (col_pos_o)
    , .col_data_o (col_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  // Row steps of 145 keep the five rows of a column apart
  // Odd column step keeps the pixels of a line unique
  function automatic logic [PIXEL_W-1:0] pixel_value(input logic [7:0] base, input int r,
                                                     input int c);
    return PIXEL_W'(base + r * 145 + c * 7);
  endfunction

  task automatic fill_frame(input frame_case_t fc);
    for (int r = 0; r < fc.height; r++) begin
      for (int c = 0; c < fc.width; c++) begin
        frame_pix[r][c] = pixel_value(fc.base, r, c);
      end
    end
  endtask

  // Newest line r yields a column once two lines sit above it
  task automatic queue_expected_columns(input frame_case_t fc);
    col_beat_t beat;
    for (int r = 2; r < fc.height; r++) begin
      for (int c = 0; c < fc.width; c++) begin
        beat = '0;
        beat.pos.w2 = (c == 0);
        beat.pos.w1 = (c == 1);
        beat.pos.e1 = (c == fc.width - 2);
        beat.pos.e2 = (c == fc.width - 1);
        beat.pos.n2 = (r == 2);
        beat.pos.n1 = (r == 3);
        for (int i = 0; i < conv_geom_pkg::KERNEL_ROWS; i++) begin
          // Rows above the frame top hold stale buffer contents
          if (r - i >= 0) begin
            beat.row_mask[i] = 1'b1;
            beat.data[i]     = frame_pix[r - i][c];
          end
        end
        expect_q.push_back(beat);
      end
    end
  endtask

  // Holds the beat until it is taken, with random valid and ready gaps
  task automatic send_pixel(input logic [PIXEL_W-1:0] data, input logic sof, input logic eol,
                            input int valid_pct, input int ready_pct);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      m_tready_i = ($urandom_range(99) < ready_pct);
      s_tvalid_i = ($urandom_range(99) < valid_pct);
      s_tdata_i  = data;
      s_tuser_i  = sof;
      s_tlast_i  = eol;
      @(posedge clk);
      taken = s_tvalid_i & m_tready_i;
    end
  endtask

  task automatic send_frame(input frame_case_t fc);
    for (int r = 0; r < fc.height; r++) begin
      for (int c = 0; c < fc.width; c++) begin
        send_pixel(frame_pix[r][c], (r == 0) && (c == 0), c == fc.width - 1,
                   fc.valid_pct, fc.ready_pct);
      end
    end
  endtask

  // Output side is sampled at the rising edge before any register moves
  always @(posedge clk) begin : monitor_outputs
    col_beat_t exp_beat;
    if (!reset_i) begin
      check_value("s_tready_o", s_tready_o, m_tready_i);
      if ($isunknown(col_vld_o)) begin
        abort_run("col_vld_o is unknown after reset");
      end
      if (!m_tready_i) begin
        check_value("col_vld_o", col_vld_o, 1'b0);
      end
      if (col_vld_o) begin
        if (expect_q.size() == 0) begin
          abort_run("Output column produced while no column was expected");
        end else begin
          exp_beat = expect_q.pop_front();
          check_value("col_pos_o", col_pos_o, exp_beat.pos);
          for (int k = 0; k < conv_geom_pkg::KERNEL_ROWS; k++) begin
            if (exp_beat.row_mask[k]) begin
              check_value($sformatf("col_data_o[%0d]", k), col_data_o[k], exp_beat.data[k]);
            end
          end
        end
      end
    end
  end

  always @(posedge clk) begin : watch_timeout
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      abort_run($sformatf("Timeout, run still busy after %0d cycles", cycle_limit));
    end
  end

  initial begin : run_tests
    frame_case_t pad;
    void'($urandom(60));
    reset_i    = 1'b1;
    s_tvalid_i = 1'b0;
    s_tdata_i  = '0;
    s_tuser_i  = 1'b0;
    s_tlast_i  = 1'b0;
    m_tready_i = 1'b1;

    // Budget of four cycles per pixel plus slack for reset and flush
    cycle_limit = 200;
    for (int f = 0; f < NUM_CASES; f++) begin
      cycle_limit = cycle_limit + FRAME_CASES[f].width * FRAME_CASES[f].height * 4;
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;

    // Idle pipe must stay quiet
    repeat (10) begin
      @(posedge clk);
      check_value("col_vld_o", col_vld_o, 1'b0);
    end

    for (int f = 0; f < NUM_CASES; f++) begin
      fill_frame(FRAME_CASES[f]);
      queue_expected_columns(FRAME_CASES[f]);
      send_frame(FRAME_CASES[f]);
    end

    // Three accepted pixels push the last real one out of stage 3
    pad = '{width: 3, height: 1, valid_pct: 100, ready_pct: 100, base: 8'hee};
    fill_frame(pad);
    send_frame(pad);

    @(negedge clk);
    s_tvalid_i = 1'b0;
    m_tready_i = 1'b1;
    repeat (4) @(negedge clk);

    if (expect_q.size() != 0) begin
      $display("Run ended with %0d expected columns never produced", expect_q.size());
      $display("=== FAIL ===");
      $fatal(1, "missing output columns");
    end else begin
      $display("=== PASS ===");
      $finish;
    end
  end

endmodule : tb_conv_top
